// ==== src/fcc_pkg.sv ====
/*
 * Shared definitions for the fully connected layer accelerator
 * Sizes, payload types and the controller state encoding
 */

package fcc_pkg;

  // ============================================================
  // Sizes
  // ============================================================

  // Byte address width of all memory ports
  localparam int ADDR_WIDTH = 19;
  // Bytes per chunk, also the multiplier lane count
  localparam int DP_DEPTH = 32;
  localparam int CHUNKS_PER_ROW = 4;
  localparam int ROW_BYTES = DP_DEPTH * CHUNKS_PER_ROW;
  localparam int MAX_ROWS = 128;
  // One written word per row
  localparam int RESULT_BYTES = 4;

  // Signed row sum, 128 products of 255 x -128 fit easily
  localparam int ACC_WIDTH = 24;
  localparam int RESULT_WIDTH = 8 * RESULT_BYTES;

  // ============================================================
  // Types
  // ============================================================

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Wide enough to hold MAX_ROWS itself
  typedef logic [$clog2(MAX_ROWS + 1)-1:0] row_t;
  typedef logic [$clog2(CHUNKS_PER_ROW)-1:0] chunk_idx_t;

  // Byte k sits at bits 8k+7 down to 8k
  typedef logic [8*DP_DEPTH-1:0] chunk_t;

  typedef logic signed [7:0] bias_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // Never negative after the rectifier
  typedef logic [RESULT_WIDTH-1:0] result_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    ACCUM = 2'd2,
    WRITE = 2'd3
  } fcc_state_t;

endpackage

// ==== src/fcc_fetch.sv ====
/*
 * fcc fetch unit
 * Issues the data, weight and bias reads for one chunk, captures the
 * returned values and signals when the whole chunk is in
 */

`timescale 1ns/10ps

module fcc_fetch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_start,
  input  fcc_pkg::row_t      row_idx,
  input  fcc_pkg::chunk_idx_t chunk_idx,
  input  fcc_pkg::addr_t     fc_addrx,
  input  fcc_pkg::addr_t     fc_addry,
  input  fcc_pkg::addr_t     fc_addrb,
  output logic               pic_req,
  output logic               wgt_req,
  output logic               bias_req,
  output fcc_pkg::addr_t     pic_addr,
  output fcc_pkg::addr_t     wgt_addr,
  output fcc_pkg::addr_t     bias_addr,
  input  logic               pic_valid,
  input  logic               wgt_valid,
  input  logic               bias_valid,
  input  fcc_pkg::chunk_t    pic_data,
  input  fcc_pkg::chunk_t    wgt_data,
  input  fcc_pkg::bias_t     bias_data,
  output fcc_pkg::chunk_t    pic_chunk,
  output fcc_pkg::chunk_t    wgt_chunk,
  output fcc_pkg::bias_t     row_bias,
  output logic               chunk_ready
);

  import fcc_pkg::*;

  // Pending state after this cycle's answers
  logic pic_pend_nxt;
  logic wgt_pend_nxt;
  logic bias_pend_nxt;
  logic any_pend;

  // A req stays high until its channel answers
  assign pic_pend_nxt  = pic_req & ~pic_valid;
  assign wgt_pend_nxt  = wgt_req & ~wgt_valid;
  assign bias_pend_nxt = bias_req & ~bias_valid;
  assign any_pend      = pic_req | wgt_req | bias_req;

  // ============================================================
  // Request flags, one per channel, doubling as pending flags
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pic_req     <= 1'b0;
      wgt_req     <= 1'b0;
      bias_req    <= 1'b0;
      chunk_ready <= 1'b0;
    end
    else
    begin
      // Last outstanding answer seen this cycle
      chunk_ready <= any_pend & ~(pic_pend_nxt | wgt_pend_nxt | bias_pend_nxt);
      if (fetch_start)
      begin
        pic_req  <= 1'b1;
        wgt_req  <= 1'b1;
        // Bias only once per row
        bias_req <= (chunk_idx == '0);
      end
      else
      begin
        pic_req  <= pic_pend_nxt;
        wgt_req  <= wgt_pend_nxt;
        bias_req <= bias_pend_nxt;
      end
    end
  end

  // Addresses latched at start, steady while the reqs are up
  always_ff @(posedge clk)
  begin
    if (fetch_start)
    begin
      pic_addr  <= fc_addrx + (addr_t'(chunk_idx) << $clog2(DP_DEPTH));
      wgt_addr  <= fc_addry + (addr_t'(row_idx) << $clog2(ROW_BYTES))
                 + (addr_t'(chunk_idx) << $clog2(DP_DEPTH));
      bias_addr <= fc_addrb + addr_t'(row_idx);
    end
  end

  // Returned chunks and bias, held until the next answer
  always_ff @(posedge clk)
  begin
    if (pic_req && pic_valid)
      pic_chunk <= pic_data;
    if (wgt_req && wgt_valid)
      wgt_chunk <= wgt_data;
    // Kept through all chunks of the row
    if (bias_req && bias_valid)
      row_bias <= bias_data;
  end

endmodule

// ==== src/fcc_mac.sv ====
/*
 * fcc multiply-accumulate unit
 * 32-lane unsigned by signed byte multiply, adder tree over the lanes
 * and the row accumulator across chunks
 */

`timescale 1ns/10ps

module fcc_mac (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mac_clear,
  input  logic            mac_add,
  input  fcc_pkg::chunk_t pic_chunk,
  input  fcc_pkg::chunk_t wgt_chunk,
  output fcc_pkg::acc_t   row_acc
);

  import fcc_pkg::*;

  // Sum of the 32 products of the current chunk
  acc_t chunk_sum;

  // ============================================================
  // Lane products and adder tree
  // ============================================================
  always_comb
  begin
    // Heap layout, leaves at DP_DEPTH and up, root at 1
    acc_t tree [1:2*DP_DEPTH-1];
    for (int i = 0; i < DP_DEPTH; i++)
    begin
      // Data byte zero-extended, weight byte sign-extended
      tree[DP_DEPTH + i] = acc_t'($signed({1'b0, pic_chunk[8*i +: 8]}))
                         * acc_t'($signed(wgt_chunk[8*i +: 8]));
    end
    // Pairwise reduction, five levels for 32 lanes
    for (int n = DP_DEPTH - 1; n >= 1; n--)
    begin
      tree[n] = tree[2*n] + tree[2*n + 1];
    end
    chunk_sum = tree[1];
  end

  // Row accumulator
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      row_acc <= '0;
    else if (mac_clear)
      // New row starts from zero
      row_acc <= '0;
    else if (mac_add)
      row_acc <= row_acc + chunk_sum;
  end

endmodule

// ==== src/fcc_ctrl.sv ====
/*
 * fcc controller
 * Four-state machine stepping fetch, accumulate and write for every row,
 * with the row and chunk counters, busy level and done pulse
 */

`timescale 1ns/10ps

module fcc_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fc_go,
  input  fcc_pkg::row_t       fc_rows,
  output logic                fc_done,
  output logic                fc_busy,
  output logic                fetch_start,
  output fcc_pkg::row_t       row_idx,
  output fcc_pkg::chunk_idx_t chunk_idx,
  input  logic                chunk_ready,
  output logic                mac_clear,
  output logic                mac_add,
  output logic                write_start,
  input  logic                write_done
);

  import fcc_pkg::*;

  fcc_state_t state;
  // Row count latched at go
  row_t       rows_lat;

  // ============================================================
  // State machine and counters
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= IDLE;
      rows_lat    <= '0;
      row_idx     <= '0;
      chunk_idx   <= '0;
      fc_done     <= 1'b0;
      fc_busy     <= 1'b0;
      fetch_start <= 1'b0;
      mac_clear   <= 1'b0;
      mac_add     <= 1'b0;
      write_start <= 1'b0;
    end
    else
    begin
      // Single-cycle strobes by default
      fc_done     <= 1'b0;
      fetch_start <= 1'b0;
      mac_clear   <= 1'b0;
      mac_add     <= 1'b0;
      write_start <= 1'b0;
      case (state)
        IDLE:
        begin
          // Empty jobs are ignored
          if (fc_go && (fc_rows != '0))
          begin
            rows_lat    <= fc_rows;
            row_idx     <= '0;
            chunk_idx   <= '0;
            fetch_start <= 1'b1;
            mac_clear   <= 1'b1;
            fc_busy     <= 1'b1;
            state       <= FETCH;
          end
        end
        FETCH:
        begin
          // Wait for all reads of the chunk
          if (chunk_ready)
          begin
            mac_add <= 1'b1;
            state   <= ACCUM;
          end
        end
        ACCUM:
        begin
          if (chunk_idx == chunk_idx_t'(CHUNKS_PER_ROW - 1))
          begin
            // Row sum complete one cycle later, in time for the writer
            write_start <= 1'b1;
            state       <= WRITE;
          end
          else
          begin
            chunk_idx   <= chunk_idx + 1'b1;
            fetch_start <= 1'b1;
            state       <= FETCH;
          end
        end
        WRITE:
        begin
          if (write_done)
          begin
            if (row_idx == row_t'(rows_lat - 1'b1))
            begin
              // Last row acknowledged
              fc_done <= 1'b1;
              fc_busy <= 1'b0;
              state   <= IDLE;
            end
            else
            begin
              row_idx     <= row_idx + 1'b1;
              chunk_idx   <= '0;
              fetch_start <= 1'b1;
              mac_clear   <= 1'b1;
              state       <= FETCH;
            end
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

endmodule

// ==== src/fcc_writer.sv ====
/*
 * fcc result writer
 * Adds the row bias, clips negative totals to zero and holds the write
 * request with its address and word until acknowledged
 */

`timescale 1ns/10ps

module fcc_writer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             write_start,
  input  fcc_pkg::row_t    row_idx,
  input  fcc_pkg::acc_t    row_acc,
  input  fcc_pkg::bias_t   row_bias,
  input  fcc_pkg::addr_t   fc_addrz,
  output logic             wr_req,
  output fcc_pkg::addr_t   wr_addr,
  output fcc_pkg::result_t wr_data,
  input  logic             wr_ack,
  output logic             write_done
);

  import fcc_pkg::*;

  // Row total before the rectifier
  acc_t biased_sum;

  // Bias byte sign-extended to the accumulator width
  assign biased_sum = row_acc + acc_t'(row_bias);

  // Ack cycle of a pending write
  assign write_done = wr_req & wr_ack;

  // ============================================================
  // Write request
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_req <= 1'b0;
    else if (write_start)
      wr_req <= 1'b1;
    else if (wr_ack)
      // Drops the cycle after the ack
      wr_req <= 1'b0;
  end

  // Address and word, steady while the request is up
  always_ff @(posedge clk)
  begin
    if (write_start)
    begin
      // One word per row
      wr_addr <= fc_addrz + (addr_t'(row_idx) << $clog2(RESULT_BYTES));
      // Rectifier
      if (biased_sum < 0)
        wr_data <= '0;
      else
        wr_data <= result_t'(biased_sum);
    end
  end

endmodule

// ==== src/fcc.sv ====
/*
 * fcc top level
 * Fully connected layer accelerator, connects the fetch unit, the
 * controller, the multiply-accumulate unit and the result writer
 */

`timescale 1ns/10ps

module fcc (
  input  logic             clk,
  input  logic             rst_n,
  // Job control
  input  logic             fc_go,
  input  fcc_pkg::row_t    fc_rows,
  input  fcc_pkg::addr_t   fc_addrx,
  input  fcc_pkg::addr_t   fc_addry,
  input  fcc_pkg::addr_t   fc_addrb,
  input  fcc_pkg::addr_t   fc_addrz,
  output logic             fc_done,
  output logic             fc_busy,
  // Data read channel
  output logic             pic_req,
  output fcc_pkg::addr_t   pic_addr,
  input  logic             pic_valid,
  input  fcc_pkg::chunk_t  pic_data,
  // Weight read channel
  output logic             wgt_req,
  output fcc_pkg::addr_t   wgt_addr,
  input  logic             wgt_valid,
  input  fcc_pkg::chunk_t  wgt_data,
  // Bias read channel
  output logic             bias_req,
  output fcc_pkg::addr_t   bias_addr,
  input  logic             bias_valid,
  input  fcc_pkg::bias_t   bias_data,
  // Result write channel
  output logic             wr_req,
  output fcc_pkg::addr_t   wr_addr,
  output fcc_pkg::result_t wr_data,
  input  logic             wr_ack
);

  import fcc_pkg::*;

  // Controller to fetch unit
  logic       fetch_start;
  row_t       row_idx;
  chunk_idx_t chunk_idx;
  logic       chunk_ready;
  // Fetched operands
  chunk_t     pic_chunk;
  chunk_t     wgt_chunk;
  bias_t      row_bias;
  // Controller to accumulator and writer
  logic       mac_clear;
  logic       mac_add;
  acc_t       row_acc;
  logic       write_start;
  logic       write_done;

  // ============================================================
  // Input side
  // ============================================================
  fcc_fetch fetch_i (
    .clk, .rst_n, .fetch_start, .row_idx, .chunk_idx,
    .fc_addrx, .fc_addry, .fc_addrb,
    .pic_req, .wgt_req, .bias_req,
    .pic_addr, .wgt_addr, .bias_addr,
    .pic_valid, .wgt_valid, .bias_valid,
    .pic_data, .wgt_data, .bias_data,
    .pic_chunk, .wgt_chunk, .row_bias, .chunk_ready
  );

  // Processing
  fcc_ctrl ctrl_i (
    .clk, .rst_n, .fc_go, .fc_rows, .fc_done, .fc_busy,
    .fetch_start, .row_idx, .chunk_idx, .chunk_ready,
    .mac_clear, .mac_add, .write_start, .write_done
  );

  fcc_mac mac_i (
    .clk, .rst_n, .mac_clear, .mac_add,
    .pic_chunk, .wgt_chunk, .row_acc
  );

  // Output side
  fcc_writer writer_i (
    .clk, .rst_n, .write_start, .row_idx, .row_acc, .row_bias,
    .fc_addrz, .wr_req, .wr_addr, .wr_data, .wr_ack, .write_done
  );

endmodule

// ==== test/fcc_chk.sv ====
/*
 * fcc protocol checker
 * Bound into the top level, watches the memory handshakes and the
 * done and busy outputs
 */

`timescale 1ns/10ps

module fcc_chk (
  input logic             clk,
  input logic             rst_n,
  input logic             pic_req,
  input logic             pic_valid,
  input fcc_pkg::addr_t   pic_addr,
  input logic             wgt_req,
  input logic             wgt_valid,
  input fcc_pkg::addr_t   wgt_addr,
  input logic             bias_req,
  input logic             bias_valid,
  input fcc_pkg::addr_t   bias_addr,
  input logic             wr_req,
  input logic             wr_ack,
  input fcc_pkg::addr_t   wr_addr,
  input fcc_pkg::result_t wr_data,
  input logic             fc_done,
  input logic             fc_busy
);

  // Failed assertions so far
  int fail_cnt = 0;

  // ============================================================
  // Requests held with their address until answered
  // ============================================================
  a_pic_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pic_req && !pic_valid |=> pic_req && $stable(pic_addr))
    else
    begin
      $error("pic_req dropped or pic_addr moved before pic_valid");
      fail_cnt++;
    end

  a_wgt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_req && !wgt_valid |=> wgt_req && $stable(wgt_addr))
    else
    begin
      $error("wgt_req dropped or wgt_addr moved before wgt_valid");
      fail_cnt++;
    end

  a_bias_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bias_req && !bias_valid |=> bias_req && $stable(bias_addr))
    else
    begin
      $error("bias_req dropped or bias_addr moved before bias_valid");
      fail_cnt++;
    end

  // Write word and address steady too
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_ack |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else
    begin
      $error("wr_req, wr_addr or wr_data changed before wr_ack");
      fail_cnt++;
    end

  // Done and busy
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    fc_done |=> !fc_done)
    else
    begin
      $error("fc_done high for more than one cycle");
      fail_cnt++;
    end

  a_busy_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    fc_done |=> !fc_busy)
    else
    begin
      $error("fc_busy high in the cycle after fc_done");
      fail_cnt++;
    end

endmodule

bind fcc fcc_chk chk_i (
  .clk, .rst_n,
  .pic_req, .pic_valid, .pic_addr,
  .wgt_req, .wgt_valid, .wgt_addr,
  .bias_req, .bias_valid, .bias_addr,
  .wr_req, .wr_ack, .wr_addr, .wr_data,
  .fc_done, .fc_busy
);

// ==== test/fcc_tb.sv ====
/*
 * fcc testbench
 * LFSR-filled memories with random response latency, a reference model
 * per row, address and word checks, done and busy monitoring
 */

`timescale 1ns/10ps

module fcc_tb;

  import fcc_pkg::*;

  localparam int MAX_LAT = 7;
  localparam int TOTAL_ROWS = 5 + 1 + MAX_ROWS;
  // Worst case per chunk and per write times two
  localparam int WATCHDOG_CYCLES =
    2 * TOTAL_ROWS * (CHUNKS_PER_ROW + 1) * (MAX_LAT + 8) + 2000;

  logic    clk;
  logic    rst_n;
  logic    fc_go;
  row_t    fc_rows;
  addr_t   fc_addrx, fc_addry, fc_addrb, fc_addrz;
  logic    fc_done, fc_busy;
  logic    pic_req, wgt_req, bias_req, wr_req;
  logic    pic_valid, wgt_valid, bias_valid, wr_ack;
  addr_t   pic_addr, wgt_addr, bias_addr, wr_addr;
  chunk_t  pic_data, wgt_data;
  bias_t   bias_data;
  result_t wr_data;

  logic [31:0] lfsr = 32'h2c3c;

  // Memory contents
  logic [7:0] data_mem [ROW_BYTES];
  bias_t      wgt_mem [MAX_ROWS][ROW_BYTES];
  bias_t      bias_mem [MAX_ROWS];

  // Cumulative traffic counts and their values at the start of a run
  int pic_cnt = 0, wgt_cnt = 0, bias_cnt = 0, wr_cnt = 0, done_cnt = 0;
  int pic_base = 0, wgt_base = 0, bias_base = 0, wr_base = 0, done_base = 0;
  int run_rows = 0;
  int value_errs = 0, other_errs = 0;

  fcc fcc_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ============================================================
  // Random source, reference model and compare tasks
  // ============================================================

  // Galois LFSR on x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // Bias plus dot product clipped at zero
  function automatic result_t model_result(input int r);
    int sum;
    sum = int'(bias_mem[r]);
    for (int k = 0; k < ROW_BYTES; k++)
      sum += int'(data_mem[k]) * int'(wgt_mem[r][k]);
    return (sum < 0) ? '0 : result_t'(sum);
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic fill_memories();
    for (int k = 0; k < ROW_BYTES; k++)
      data_mem[k] = 8'(rand_bits(8));
    for (int r = 0; r < MAX_ROWS; r++)
    begin
      bias_mem[r] = 8'(rand_bits(8));
      for (int k = 0; k < ROW_BYTES; k++)
      begin
        wgt_mem[r][k] = 8'(rand_bits(8));
        // Negative weights on rows 1 mod 3 so they clip
        // Positive weights on rows 2 mod 3
        if (r % 3 == 1)
          wgt_mem[r][k][7] = 1'b1;
        else if (r % 3 == 2)
          wgt_mem[r][k][7] = 1'b0;
      end
    end
  endtask

  // ============================================================
  // Memory responders
  // ============================================================
  initial
  begin
    int lat;
    int c;
    pic_valid = 1'b0;
    pic_data = '0;
    forever
    begin
      @(posedge clk);
      if (pic_req)
      begin
        c = pic_cnt % CHUNKS_PER_ROW;
        check_addr("pic_addr", pic_addr, fc_addrx + addr_t'(DP_DEPTH * c));
        lat = rand_bits(3);
        pic_cnt++;
        repeat (lat) @(posedge clk);
        #2;
        for (int k = 0; k < DP_DEPTH; k++)
          pic_data[8*k +: 8] = data_mem[DP_DEPTH*c + k];
        pic_valid = 1'b1;
        @(posedge clk);
        #2 pic_valid = 1'b0;
      end
    end
  end

  initial
  begin
    int lat;
    int r;
    int c;
    wgt_valid = 1'b0;
    wgt_data = '0;
    forever
    begin
      @(posedge clk);
      if (wgt_req)
      begin
        r = (wgt_cnt - wgt_base) / CHUNKS_PER_ROW;
        c = (wgt_cnt - wgt_base) % CHUNKS_PER_ROW;
        check_addr("wgt_addr", wgt_addr, fc_addry + addr_t'(ROW_BYTES * r + DP_DEPTH * c));
        lat = rand_bits(3);
        wgt_cnt++;
        repeat (lat) @(posedge clk);
        #2;
        for (int k = 0; k < DP_DEPTH; k++)
          wgt_data[8*k +: 8] = wgt_mem[r][DP_DEPTH*c + k];
        wgt_valid = 1'b1;
        @(posedge clk);
        #2 wgt_valid = 1'b0;
      end
    end
  end

  // One bias read per row in row order
  initial
  begin
    int lat;
    int r;
    bias_valid = 1'b0;
    bias_data = '0;
    forever
    begin
      @(posedge clk);
      if (bias_req)
      begin
        r = bias_cnt - bias_base;
        check_addr("bias_addr", bias_addr, fc_addrb + addr_t'(r));
        lat = rand_bits(3);
        bias_cnt++;
        repeat (lat) @(posedge clk);
        #2 bias_data = bias_mem[r];
        bias_valid = 1'b1;
        @(posedge clk);
        #2 bias_valid = 1'b0;
      end
    end
  end

  // Write sink expecting words in row order
  initial
  begin
    int lat;
    int r;
    wr_ack = 1'b0;
    forever
    begin
      @(posedge clk);
      if (wr_req)
      begin
        r = wr_cnt - wr_base;
        if (r >= run_rows)
        begin
          other_errs++;
          $display("Write request beyond the last row of the job");
        end
        check_addr("wr_addr", wr_addr, fc_addrz + addr_t'(RESULT_BYTES * r));
        check_result("wr_data", wr_data, model_result(r));
        lat = rand_bits(3);
        repeat (lat) @(posedge clk);
        #2 wr_ack = 1'b1;
        @(posedge clk);
        #2 wr_ack = 1'b0;
        wr_cnt++;
      end
    end
  end

  // Done pulse count and no traffic outside busy
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (fc_done)
        done_cnt++;
      if ((pic_req || wgt_req || bias_req || wr_req) && !fc_busy)
      begin
        other_errs++;
        $display("Memory request seen while fc_busy was low");
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  // ============================================================
  // Job sequencing
  // ============================================================
  task automatic take_snapshot(input int rows);
    run_rows = rows;
    pic_base = pic_cnt;
    wgt_base = wgt_cnt;
    bias_base = bias_cnt;
    wr_base = wr_cnt;
    done_base = done_cnt;
  endtask

  task automatic run_job(input row_t rows);
    bit busy_low;
    busy_low = 1'b0;
    @(posedge clk);
    #2;
    fc_addrx = addr_t'(rand_bits(16));
    fc_addry = addr_t'(rand_bits(16));
    fc_addrb = addr_t'(rand_bits(16));
    fc_addrz = addr_t'(rand_bits(16));
    fc_rows = rows;
    take_snapshot(int'(rows));
    fc_go = 1'b1;
    @(posedge clk);
    #2 fc_go = 1'b0;
    // A second go in mid-job has to be ignored
    repeat (10) @(posedge clk);
    if (!fc_busy)
    begin
      other_errs++;
      $display("fc_busy low ten cycles into a job of %0d rows", run_rows);
    end
    #2 fc_go = 1'b1;
    fc_rows = 8'd3;
    @(posedge clk);
    #2 fc_go = 1'b0;
    // Busy stays up until the done pulse
    while (!fc_done)
    begin
      if (!fc_busy && !busy_low)
      begin
        busy_low = 1'b1;
        other_errs++;
        $display("fc_busy dropped before fc_done in a job of %0d rows", run_rows);
      end
      @(posedge clk);
    end
    // Every write acknowledged by the time done shows up
    if (wr_cnt - wr_base != run_rows)
    begin
      other_errs++;
      $display("fc_done came after %0d of %0d writes", wr_cnt - wr_base, run_rows);
    end
    repeat (3) @(posedge clk);
    if (wr_cnt - wr_base != run_rows || bias_cnt - bias_base != run_rows
        || pic_cnt - pic_base != CHUNKS_PER_ROW * run_rows
        || wgt_cnt - wgt_base != CHUNKS_PER_ROW * run_rows
        || done_cnt - done_base != 1)
    begin
      other_errs++;
      $display("Job of %0d rows gave %0d writes, %0d bias, %0d data, %0d weight reads, %0d dones",
               run_rows, wr_cnt - wr_base, bias_cnt - bias_base, pic_cnt - pic_base,
               wgt_cnt - wgt_base, done_cnt - done_base);
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    fc_go = 1'b0;
    fc_rows = '0;
    fc_addrx = '0;
    fc_addry = '0;
    fc_addrb = '0;
    fc_addrz = '0;
    fill_memories();
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    if (fc_done || fc_busy || pic_req || wgt_req || bias_req || wr_req)
    begin
      other_errs++;
      $display("Control output or request high right after reset");
    end
    // A go with zero rows starts nothing
    take_snapshot(0);
    #2 fc_go = 1'b1;
    @(posedge clk);
    #2 fc_go = 1'b0;
    repeat (20) @(posedge clk);
    if (pic_cnt != pic_base || bias_cnt != bias_base || done_cnt != done_base || fc_busy)
    begin
      other_errs++;
      $display("A go with zero rows started the DUT");
    end
    run_job(8'd5);
    run_job(8'd1);
    run_job(row_t'(MAX_ROWS));
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             value_errs, other_errs, fcc_i.chk_i.fail_cnt);
    if (value_errs == 0 && other_errs == 0 && fcc_i.chk_i.fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
src/fcc_pkg.sv
src/fcc_fetch.sv
src/fcc_mac.sv
src/fcc_ctrl.sv
src/fcc_writer.sv
src/fcc.sv
test/fcc_chk.sv
test/fcc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fcc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fcc_tb -f verilog.f -o fcc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Keep going after an assertion error so the testbench can report it
out=$(./obj_dir/fcc_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
